// File: rtl/ahbl_pkg.sv
// ----------------------------------------
// shared AHB-Lite types for a 32-bit bus with word transfers only.
// HRESP, HSIZE, HBURST and HPROT are not carried.
// ----------------------------------------
package ahbl_pkg;

    typedef logic [31:0] haddr_t;   // byte address on the bus.
    typedef logic [31:0] hdata_t;   // read or write data word.
    typedef logic [3:0]  page_t;    // 256 MB page taken from haddr[31:28].

    // AHB transfer type, bit 1 set means a real transfer.
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    // request broadcast from the master port to every slave.
    typedef struct packed {
        haddr_t  haddr;     // address phase.
        htrans_e htrans;    // address phase.
        logic    hwrite;    // address phase.
        hdata_t  hwdata;    // data phase, one cycle after its address.
        logic    hready;    // bus level ready from the splitter.
    } ahbl_req_t;

    // response returned by each slave to the splitter.
    typedef struct packed {
        hdata_t hrdata;
        logic   hreadyout;
    } ahbl_rsp_t;

    // read data of any access to an unmapped page.
    localparam hdata_t UNMAPPED_DATA = 32'hBADDBEEF;

endpackage

// File: rtl/ahbl_splitter.sv
// ----------------------------------------
// four slaves on four distinct 256 MB pages, the rest is unmapped.
// unmapped accesses finish at once with BADDBEEF and no error.
// ----------------------------------------
`timescale 1ns/1ps

module ahbl_splitter #(
    parameter ahbl_pkg::page_t PAGE_S0 = 4'h0,
    parameter ahbl_pkg::page_t PAGE_S1 = 4'h2,
    parameter ahbl_pkg::page_t PAGE_S2 = 4'h4,
    parameter ahbl_pkg::page_t PAGE_S3 = 4'h8
) (
    input  logic                HCLK,
    input  logic                HRESETn,

    input  ahbl_pkg::haddr_t    haddr,
    input  ahbl_pkg::htrans_e   htrans,
    output logic                hready,
    output ahbl_pkg::hdata_t    hrdata,

    output logic [3:0]          hsel,
    input  ahbl_pkg::ahbl_rsp_t slave_rsp [4]
);

    ahbl_pkg::page_t page;
    logic [3:0]      sel_d;    // slave that owns the current data phase.

    assign page = haddr[31:28];

    // address decode, combinational so the slave sees hsel in the address phase.
    always_comb begin
        hsel[0] = (page == PAGE_S0);
        hsel[1] = (page == PAGE_S1);
        hsel[2] = (page == PAGE_S2);
        hsel[3] = (page == PAGE_S3);
    end

    // the select moves to the data phase only when an address phase is accepted.
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            sel_d <= 4'b0000;
        end else if (htrans[1] && hready) begin
            sel_d <= hsel;     // an unmapped page loads all zero.
        end
    end

    // response mux. With no slave selected the bus is ready and reads BADDBEEF.
    always_comb begin
        hready = 1'b1;
        hrdata = ahbl_pkg::UNMAPPED_DATA;
        for (int i = 0; i < 4; i++) begin
            if (sel_d[i]) begin
                hready = slave_rsp[i].hreadyout;
                hrdata = slave_rsp[i].hrdata;
            end
        end
    end

    // two slaves on the same page would make the response mux ambiguous.
    a_sel_d_onehot0: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        $onehot0(sel_d)
    ) else $error("data phase select is not one-hot: %b", sel_d);

endmodule

// File: rtl/ahbl_sram.sv
// ----------------------------------------
// word memory, haddr[1:0] and the bits above the array size are ignored.
// every access inserts exactly WAIT_STATES low cycles of hreadyout.
// ----------------------------------------
`timescale 1ns/1ps

module ahbl_sram #(
    parameter int ADDR_WORDS_LOG2 = 8,
    parameter int WAIT_STATES     = 0
) (
    input  logic                HCLK,
    input  logic                HRESETn,

    input  logic                hsel,
    input  ahbl_pkg::ahbl_req_t req,
    output ahbl_pkg::ahbl_rsp_t rsp
);

    localparam int CNT_W = (WAIT_STATES > 1) ? $clog2(WAIT_STATES + 1) : 1;

    typedef logic [ADDR_WORDS_LOG2-1:0] word_addr_t;
    typedef logic [CNT_W-1:0]           wait_cnt_t;

    typedef enum logic [1:0] {
        SRAM_IDLE,
        SRAM_WAIT,
        SRAM_DONE
    } sram_state_e;

    sram_state_e      state;
    wait_cnt_t        wait_cnt;     // wait cycles still to go, counting down.
    word_addr_t       addr_q;
    logic             write_q;
    logic             accept;
    ahbl_pkg::hdata_t mem [2**ADDR_WORDS_LOG2];

    assign accept = hsel && req.htrans[1] && req.hready;

    // a new address phase can only be seen while the bus is ready.
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state    <= SRAM_IDLE;
            wait_cnt <= '0;
            write_q  <= 1'b0;
        end else begin
            case (state)
                SRAM_WAIT: begin
                    if (wait_cnt == '0) begin
                        state <= SRAM_DONE;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                SRAM_IDLE, SRAM_DONE: begin
                    if (accept) begin
                        write_q <= req.hwrite;
                        if (WAIT_STATES == 0) begin
                            state <= SRAM_DONE;
                        end else begin
                            state    <= SRAM_WAIT;
                            wait_cnt <= wait_cnt_t'(WAIT_STATES - 1);
                        end
                    end else begin
                        state <= SRAM_IDLE;
                    end
                end
                default: state <= SRAM_IDLE;
            endcase
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            addr_q <= req.haddr[ADDR_WORDS_LOG2+1:2];    // byte address to word index.
        end
    end

    // hwdata is valid in the last data phase cycle, so the write lands there.
    always_ff @(posedge HCLK) begin
        if ((state == SRAM_DONE) && write_q) begin
            mem[addr_q] <= req.hwdata;
        end
    end

    assign rsp.hreadyout = (state != SRAM_WAIT);
    assign rsp.hrdata    = mem[addr_q];

    // the bus sees at most WAIT_STATES low cycles from this slave.
    a_wait_bound: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        $fell(rsp.hreadyout) |-> ##WAIT_STATES rsp.hreadyout
    ) else $error("hreadyout held low longer than %0d cycles", WAIT_STATES);

endmodule

// File: rtl/ahbl_fifo.sv
// ----------------------------------------
// offset 0 pushes on write and pops on read, offset 4 reads the count.
// a read when empty gives 0 and a write when full is dropped.
// ----------------------------------------
`timescale 1ns/1ps

module ahbl_fifo #(
    parameter int DEPTH_LOG2 = 4
) (
    input  logic                HCLK,
    input  logic                HRESETn,

    input  logic                hsel,
    input  ahbl_pkg::ahbl_req_t req,
    output ahbl_pkg::ahbl_rsp_t rsp
);

    localparam int DEPTH = 2**DEPTH_LOG2;

    typedef logic [DEPTH_LOG2-1:0] ptr_t;
    typedef logic [DEPTH_LOG2:0]   count_t;

    ptr_t             wr_ptr;
    ptr_t             rd_ptr;
    count_t           count;
    logic             accept;
    logic             active_q;     // this slave owns the current data phase.
    logic             write_q;
    logic             count_reg_q;  // data phase targets the count register.
    logic             empty;
    logic             full;
    logic             push;
    logic             pop;
    ahbl_pkg::hdata_t mem [DEPTH];

    assign accept = hsel && req.htrans[1] && req.hready;
    assign empty  = (count == '0);
    assign full   = (count == count_t'(DEPTH));

    // phase information for the data phase that follows.
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            active_q    <= 1'b0;
            write_q     <= 1'b0;
            count_reg_q <= 1'b0;
        end else begin
            active_q <= accept;
            if (accept) begin
                write_q     <= req.hwrite;
                count_reg_q <= req.haddr[2];
            end
        end
    end

    // the data phase always completes in one cycle, so it acts right away.
    assign push = active_q && write_q && !count_reg_q && !full;
    assign pop  = active_q && !write_q && !count_reg_q && !empty;

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps at DEPTH.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge HCLK) begin
        if (push) begin
            mem[wr_ptr] <= req.hwdata;
        end
    end

    // read data follows the latched offset, a pop shows the head entry.
    always_comb begin
        if (count_reg_q) begin
            rsp.hrdata = ahbl_pkg::hdata_t'(count);
        end else if (empty) begin
            rsp.hrdata = '0;
        end else begin
            rsp.hrdata = mem[rd_ptr];
        end
    end

    assign rsp.hreadyout = 1'b1;    // zero wait, never stalls the bus.

    a_count_bound: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        count <= count_t'(DEPTH)
    ) else $error("fifo count %0d exceeds depth %0d", count, DEPTH);

endmodule

// File: rtl/ahbl_subsystem.sv
// ----------------------------------------
// one AHB-Lite master port, slaves on pages 0, 2, 4 and 8.
// page 4 adds two wait states, all other pages are zero wait.
// ----------------------------------------
`timescale 1ns/1ps

module ahbl_subsystem (
    input  logic              HCLK,
    input  logic              HRESETn,

    input  ahbl_pkg::haddr_t  haddr,
    input  ahbl_pkg::htrans_e htrans,
    input  logic              hwrite,
    input  ahbl_pkg::hdata_t  hwdata,
    output logic              hready,
    output ahbl_pkg::hdata_t  hrdata
);

    ahbl_pkg::ahbl_req_t req;               // same request goes to every slave.
    ahbl_pkg::ahbl_rsp_t slave_rsp [4];
    logic [3:0]          hsel;

    assign req = '{
        haddr:  haddr,
        htrans: htrans,
        hwrite: hwrite,
        hwdata: hwdata,
        hready: hready
    };

    ahbl_splitter #(
        .PAGE_S0 (4'h0),
        .PAGE_S1 (4'h2),
        .PAGE_S2 (4'h4),
        .PAGE_S3 (4'h8)
    ) u_splitter (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .haddr     (haddr),
        .htrans    (htrans),
        .hready    (hready),
        .hrdata    (hrdata),
        .hsel      (hsel),
        .slave_rsp (slave_rsp)
    );

    // page 0, 256 words with no wait.
    ahbl_sram #(
        .ADDR_WORDS_LOG2 (8),
        .WAIT_STATES     (0)
    ) u_sram_fast (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .hsel    (hsel[0]),
        .req     (req),
        .rsp     (slave_rsp[0])
    );

    // page 2, 16 entries.
    ahbl_fifo #(
        .DEPTH_LOG2 (4)
    ) u_fifo_big (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .hsel    (hsel[1]),
        .req     (req),
        .rsp     (slave_rsp[1])
    );

    // page 4, 256 words with two wait states.
    ahbl_sram #(
        .ADDR_WORDS_LOG2 (8),
        .WAIT_STATES     (2)
    ) u_sram_slow (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .hsel    (hsel[2]),
        .req     (req),
        .rsp     (slave_rsp[2])
    );

    // page 8, 4 entries.
    ahbl_fifo #(
        .DEPTH_LOG2 (2)
    ) u_fifo_small (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .hsel    (hsel[3]),
        .req     (req),
        .rsp     (slave_rsp[3])
    );

endmodule

// File: tb/tb_ahbl_subsystem.sv
// ----------------------------------------
// directed tests for single word transfers only, FIFOs empty at start.
// ----------------------------------------
`timescale 1ns/1ps

module tb_ahbl_subsystem;

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_XFERS       = 2 * 32 + 23 + 13 + 8 + 16;    // transfers over all tests.
    localparam int WATCHDOG_CYCLES = 10 + NUM_XFERS * 10 + 100;

    logic              HCLK = 1'b0;
    logic              HRESETn;
    ahbl_pkg::haddr_t  haddr;
    ahbl_pkg::htrans_e htrans;
    logic              hwrite;
    ahbl_pkg::hdata_t  hwdata;
    logic              hready;
    ahbl_pkg::hdata_t  hrdata;

    ahbl_pkg::hdata_t  sram_ref [2][256];    // bank 0 is page 0, bank 1 is page 4.
    ahbl_pkg::hdata_t  fifo_ref [$];
    int                seed       = 32'h22733066;
    int                errors     = 0;
    int                tests_done = 0;

    ahbl_subsystem DUT (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .haddr   (haddr),
        .htrans  (htrans),
        .hwrite  (hwrite),
        .hwdata  (hwdata),
        .hready  (hready),
        .hrdata  (hrdata)
    );

    always #(CLK_PERIOD / 2) HCLK = ~HCLK;

    task automatic report_test(input string name, input int start_errors);
        tests_done++;
        $display("test %0d %s done with %0d errors", tests_done, name, errors - start_errors);
    endtask

    // hready only changes on rising edges, so the falling edge is a safe sample point.
    task automatic wait_ready(output int lows);
        lows = 0;
        @(negedge HCLK);
        while (!hready) begin
            lows++;
            @(negedge HCLK);
        end
    endtask

    task automatic ahb_xfer(input ahbl_pkg::haddr_t addr, input logic wr,
                            input ahbl_pkg::hdata_t wdata,
                            output ahbl_pkg::hdata_t rdata, output int lows);
        haddr  <= addr;
        htrans <= ahbl_pkg::HTRANS_NONSEQ;
        hwrite <= wr;
        wait_ready(lows);                   // the address is taken on a ready edge.
        @(posedge HCLK);
        htrans <= ahbl_pkg::HTRANS_IDLE;
        hwdata <= wdata;
        wait_ready(lows);
        rdata = hrdata;
        @(posedge HCLK);
    endtask

    task automatic ahb_write(input ahbl_pkg::haddr_t addr, input ahbl_pkg::hdata_t data);
        ahbl_pkg::hdata_t rdata;
        int               lows;
        ahb_xfer(addr, 1'b1, data, rdata, lows);
    endtask

    task automatic read_expect(input ahbl_pkg::haddr_t addr, input ahbl_pkg::hdata_t expected,
                               input int exp_lows);
        ahbl_pkg::hdata_t data;
        int               lows;
        ahb_xfer(addr, 1'b0, '0, data, lows);
        if (data !== expected) begin
            $display("ERROR hrdata at haddr 0x%08h: got 0x%08h, expected 0x%08h",
                     addr, data, expected);
            errors++;
        end
        if (lows != exp_lows) begin
            $display("ERROR hready low cycles at haddr 0x%08h: got 0x%0h, expected 0x%0h",
                     addr, lows, exp_lows);
            errors++;
        end
    endtask

    task automatic sram_roundtrip(input int bank);
        ahbl_pkg::haddr_t base;
        ahbl_pkg::hdata_t data;
        int               start_errors;
        start_errors = errors;
        base = (bank == 1) ? 32'h4000_0000 : 32'h0000_0000;
        for (int w = 1; w < 48; w += 3) begin
            data = $random(seed);
            sram_ref[bank][w] = data;
            ahb_write(base + w * 4, data);
        end
        for (int w = 1; w < 48; w += 3) begin
            read_expect(base + w * 4, sram_ref[bank][w], bank * 2);    // page 4 stalls twice.
        end
        report_test((bank == 1) ? "slow SRAM" : "zero-wait SRAM", start_errors);
    endtask

    task automatic fifo_push_pop(input ahbl_pkg::haddr_t base, input int depth,
                                 input int pushes, input string name);
        ahbl_pkg::hdata_t data;
        int               start_errors;
        start_errors = errors;
        for (int i = 0; i < pushes; i++) begin
            data = $random(seed);
            if (fifo_ref.size() < depth) begin
                fifo_ref.push_back(data);    // a full FIFO drops the word.
            end
            ahb_write(base, data);
        end
        read_expect(base + 4, fifo_ref.size(), 0);
        while (fifo_ref.size() > 0) begin
            read_expect(base, fifo_ref.pop_front(), 0);
        end
        read_expect(base + 4, 32'd0, 0);
        read_expect(base, 32'd0, 0);         // empty read gives zero.
        report_test(name, start_errors);
    endtask

    task automatic unmapped_access();
        int start_errors;
        start_errors = errors;
        read_expect(32'h1000_0000, 32'hBADDBEEF, 0);
        read_expect(32'hF000_0004, 32'hBADDBEEF, 0);
        ahb_write(32'h1000_0004, 32'h1234_5678);    // same word offset as live SRAM data.
        ahb_write(32'hF000_0000, 32'h8765_4321);    // data port offset of the FIFOs.
        read_expect(32'h0000_0004, sram_ref[0][1], 0);
        read_expect(32'h4000_0004, sram_ref[1][1], 2);
        read_expect(32'h2000_0004, 32'd0, 0);
        read_expect(32'h8000_0004, 32'd0, 0);
        report_test("unmapped pages", start_errors);
    endtask

    // write page 0, write page 4, read page 0, read page 4, with no idle cycles between.
    task automatic pipelined_traffic();
        ahbl_pkg::haddr_t addr [16];
        logic             wr [16];
        ahbl_pkg::hdata_t wdata [16];
        ahbl_pkg::hdata_t expected [16];
        int               bank;
        int               lows;
        int               start_errors;
        start_errors = errors;
        for (int i = 0; i < 16; i++) begin
            bank = i % 2;
            addr[i] = (bank == 1) ? 32'h4000_0000 : 32'h0000_0000;
            addr[i] = addr[i] + (64 + i / 4) * 4;
            wr[i] = (i % 4) < 2;
            wdata[i] = $random(seed);
            if (wr[i]) begin
                sram_ref[bank][64 + i / 4] = wdata[i];
            end
            expected[i] = sram_ref[bank][64 + i / 4];
        end
        for (int i = 0; i <= 16; i++) begin
            if (i < 16) begin
                haddr  <= addr[i];
                htrans <= ahbl_pkg::HTRANS_NONSEQ;
                hwrite <= wr[i];
            end else begin
                htrans <= ahbl_pkg::HTRANS_IDLE;
            end
            if (i > 0) begin
                hwdata <= wdata[i - 1];      // data of the transfer one step behind.
            end
            wait_ready(lows);
            if (i > 0 && !wr[i - 1] && hrdata !== expected[i - 1]) begin
                $display("ERROR hrdata at haddr 0x%08h: got 0x%08h, expected 0x%08h",
                         addr[i - 1], hrdata, expected[i - 1]);
                errors++;
            end
            @(posedge HCLK);
        end
        report_test("pipelined cross-slave traffic", start_errors);
    endtask

    initial begin
        HRESETn = 1'b0;
        haddr   = '0;
        htrans  = ahbl_pkg::HTRANS_IDLE;
        hwrite  = 1'b0;
        hwdata  = '0;
        repeat (10) @(posedge HCLK);
        HRESETn <= 1'b1;
        @(posedge HCLK);
        sram_roundtrip(0);
        sram_roundtrip(1);
        fifo_push_pop(32'h2000_0000, 16, 10, "FIFO order and count");
        fifo_push_pop(32'h8000_0000, 4, 6, "FIFO full and empty edges");
        unmapped_access();
        pipelined_traffic();
        $display("tests %0d, errors %0d", tests_done, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, a transfer never completed",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: src.f
rtl/ahbl_pkg.sv
rtl/ahbl_splitter.sv
rtl/ahbl_sram.sv
rtl/ahbl_fifo.sv
rtl/ahbl_subsystem.sv
tb/tb_ahbl_subsystem.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_ahbl_subsystem
RTL_TOP    ?= ahbl_subsystem
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   := Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
